// ==== source/bus_pkg.sv ====
package bus_pkg;

    localparam int addr_width = 32;
    localparam int data_width = 32;

    localparam logic [addr_width-1:0] out_port_addr     = 32'h1000_0000; // byte mirror only
    localparam logic [addr_width-1:0] display_port_addr = 32'h1000_0010; // loads the display word

    localparam int word_bytes   = data_width / 8;
    localparam int word_nibbles = data_width / 4;

    // same 32 bits seen two ways
    typedef union packed {
        logic [word_bytes-1:0][7:0]   bytes;   // byte 0 goes to out_byte
        logic [word_nibbles-1:0][3:0] nibbles; // nibble 0 is the rightmost digit
    } display_word_t;

endpackage

// ==== source/display_pkg.sv ====
package display_pkg;

    localparam int num_digits = 8;

    typedef logic [$clog2(num_digits)-1:0] digit_idx_t; // 0 is the rightmost digit
    typedef logic [3:0] digit_val_t;

    // active low cathodes with dp in bit 7 kept dark
    localparam logic [7:0] seg_code [16] = '{
        8'b11000000, // 0
        8'b11111001, // 1
        8'b10100100, // 2
        8'b10110000, // 3
        8'b10011001, // 4
        8'b10010010, // 5
        8'b10000010, // 6
        8'b11111000, // 7
        8'b10000000, // 8
        8'b10011000, // 9
        8'b10001000, // a
        8'b10000011, // b
        8'b11000110, // c
        8'b10100001, // d
        8'b10000110, // e
        8'b10001110  // f
    };

    localparam logic [7:0] blank_seg = 8'b11111111; // all segments off

    // about 3 ms per digit at 100 MHz
    localparam int refresh_bits_default = 18;

endpackage

// ==== source/port_decode.sv ====
`timescale 1ns/1ns

module port_decode (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           mem_la_write,
    input  logic [bus_pkg::addr_width-1:0] mem_la_addr,
    input  logic [bus_pkg::data_width-1:0] mem_la_wdata,
    output bus_pkg::display_word_t         display_word,
    output logic [7:0]                     out_byte,
    output logic                           out_byte_en
);

    import bus_pkg::*;

    logic out_hit;
    logic display_hit;

    // look-ahead strobe carries its address in the same cycle
    assign out_hit     = mem_la_write && (mem_la_addr == out_port_addr);
    assign display_hit = mem_la_write && (mem_la_addr == display_port_addr);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            out_byte_en <= 1'b0;
        end else begin
            out_byte_en <= out_hit || display_hit; // one cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            display_word <= '0;
        end else if (display_hit) begin
            display_word <= mem_la_wdata;
        end
    end

    // mirror lags the word register by one edge
    always_ff @(posedge clk) begin
        if (!resetn) begin
            out_byte <= '0;
        end else begin
            out_byte <= display_word.bytes[0];
        end
    end

endmodule

// ==== source/digit_scan.sv ====
`timescale 1ns/1ns

module digit_scan #(
    parameter int refresh_bits = display_pkg::refresh_bits_default
) (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    base_sel,
    input  bus_pkg::display_word_t  display_word,
    output display_pkg::digit_idx_t digit_idx,
    output display_pkg::digit_val_t digit_val
);

    import bus_pkg::*;
    import display_pkg::*;

    localparam int idx_bits = $bits(digit_idx_t);

    logic [refresh_bits+idx_bits-1:0] refresh_cnt;
    logic [data_width-1:0]            word_bin;
    digit_val_t                       hex_val;
    digit_val_t                       dec_val;

    // decimal digit of weight 10^idx
    function automatic digit_val_t decimal_digit(
        input logic [data_width-1:0] word,
        input digit_idx_t            idx
    );
        logic [data_width-1:0] quot;
        begin
            case (idx)
                3'd0: quot = word;
                3'd1: quot = word / 10;
                3'd2: quot = word / 100;
                3'd3: quot = word / 1000;
                3'd4: quot = word / 10000;
                3'd5: quot = word / 100000;
                3'd6: quot = word / 1000000;
                default: quot = word / 10000000;
            endcase
            if (idx == digit_idx_t'(num_digits - 1)) begin
                decimal_digit = (quot > 9) ? 4'd9 : quot[3:0]; // top digit saturates
            end else begin
                decimal_digit = 4'(quot % 10);
            end
        end
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            refresh_cnt <= '0;
        end else begin
            refresh_cnt <= refresh_cnt + 1'b1;
        end
    end

    // top bits step once per wrap of the low part
    assign digit_idx = refresh_cnt[refresh_bits +: idx_bits];

    assign word_bin = display_word;
    assign hex_val  = display_word.nibbles[digit_idx];
    assign dec_val  = decimal_digit(word_bin, digit_idx);

    assign digit_val = base_sel ? dec_val : hex_val; // high selects decimal

endmodule

// ==== source/segment_driver.sv ====
`timescale 1ns/1ns

module segment_driver (
    input  logic                                resetn,
    input  display_pkg::digit_idx_t             digit_idx,
    input  display_pkg::digit_val_t             digit_val,
    output logic [display_pkg::num_digits-1:0]  output_anodo,
    output logic [7:0]                          output_catodo
);

    import display_pkg::*;

    logic [num_digits-1:0] anode_hot;
    logic [7:0]            seg_lookup;

    always_comb begin
        anode_hot            = '0;
        anode_hot[digit_idx] = 1'b1;
    end

    assign output_anodo = ~anode_hot; // anodes are active low

    assign seg_lookup = seg_code[digit_val];

    // keep the display dark until the word is valid
    assign output_catodo = resetn ? seg_lookup : blank_seg;

endmodule

// ==== source/display_system.sv ====
`timescale 1ns/1ns

module display_system #(
    parameter int refresh_bits = display_pkg::refresh_bits_default
) (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                base_sel,
    input  logic                                mem_la_write,
    input  logic [bus_pkg::addr_width-1:0]      mem_la_addr,
    input  logic [bus_pkg::data_width-1:0]      mem_la_wdata,
    output logic [7:0]                          out_byte,
    output logic                                out_byte_en,
    output logic [display_pkg::num_digits-1:0]  output_anodo,
    output logic [7:0]                          output_catodo
);

    import bus_pkg::*;
    import display_pkg::*;

    display_word_t display_word;
    digit_idx_t    digit_idx;
    digit_val_t    digit_val;

    port_decode port_decode_i (
        .clk          (clk),
        .resetn       (resetn),
        .mem_la_write (mem_la_write),
        .mem_la_addr  (mem_la_addr),
        .mem_la_wdata (mem_la_wdata),
        .display_word (display_word),
        .out_byte     (out_byte),
        .out_byte_en  (out_byte_en)
    );

    digit_scan #(
        .refresh_bits (refresh_bits)
    ) digit_scan_i (
        .clk          (clk),
        .resetn       (resetn),
        .base_sel     (base_sel),
        .display_word (display_word),
        .digit_idx    (digit_idx),
        .digit_val    (digit_val)
    );

    segment_driver segment_driver_i (
        .resetn        (resetn),
        .digit_idx     (digit_idx),
        .digit_val     (digit_val),
        .output_anodo  (output_anodo),
        .output_catodo (output_catodo)
    );

endmodule

// ==== bench/clock_gen.sv ====
`timescale 1ns/1ns

module clock_gen (
    output logic clk,
    output logic resetn
);

    localparam int half_period  = 4; // 8 ns clock
    localparam int reset_cycles = 16;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        resetn = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        resetn <= 1'b1;
    end

endmodule

// ==== bench/display_system_assertions.sv ====
`timescale 1ns/1ns

module display_system_assertions (
    input logic                               clk,
    input logic                               resetn,
    input logic                               out_byte_en,
    input logic [display_pkg::num_digits-1:0] output_anodo,
    input logic [7:0]                         output_catodo
);

    import display_pkg::*;

    // exactly one digit lit at a time
    one_anode: assert property (@(posedge clk) disable iff (!resetn)
        $onehot(~output_anodo))
        else $error("anodes %b do not select exactly one digit", output_anodo);

    single_pulse: assert property (@(posedge clk) disable iff (!resetn)
        out_byte_en |=> !out_byte_en)
        else $error("out_byte_en high for two cycles in a row");

    blank_in_reset: assert property (@(posedge clk)
        !resetn |-> (output_catodo == blank_seg))
        else $error("cathodes %h not blank during reset", output_catodo);

endmodule

bind display_system display_system_assertions display_system_assertions_i (
    .clk           (clk),
    .resetn        (resetn),
    .out_byte_en   (out_byte_en),
    .output_anodo  (output_anodo),
    .output_catodo (output_catodo)
);

// ==== bench/display_system_tb.sv ====
`timescale 1ns/1ns

module display_system_tb;

    import bus_pkg::*;
    import display_pkg::*;

    localparam int num_fixed      = 9;
    localparam int num_tests      = 15;
    localparam int scan_cycles    = 32; // 8 digits of 4 cycles each
    localparam int timeout_cycles = num_tests * 40 + 100;

    // active low cathodes with the dot in bit 7
    localparam logic [7:0] seg_ref [16] = '{
        8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
        8'h80, 8'h98, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E
    };

    logic                  clk;
    logic                  resetn;
    logic                  base_sel;
    logic                  mem_la_write;
    logic [addr_width-1:0] mem_la_addr;
    logic [data_width-1:0] mem_la_wdata;
    logic [7:0]            out_byte;
    logic                  out_byte_en;
    logic [7:0]            output_anodo;
    logic [7:0]            output_catodo;

    string       name_tab [num_tests];
    logic [31:0] addr_tab [num_tests];
    logic [31:0] data_tab [num_tests];
    logic        base_tab [num_tests];
    logic        en_tab   [num_tests];
    logic [7:0]  byte_tab [num_tests];

    integer      seed;
    logic [31:0] model_word; // word the display should show
    int          errors;
    int          test_errs;
    int          tests_run;
    int          tests_failed;
    int          cycle_cnt = 0;

    clock_gen clock_gen_i (
        .clk    (clk),
        .resetn (resetn)
    );

    display_system #(
        .refresh_bits (2)
    ) display_system_i (
        .clk           (clk),
        .resetn        (resetn),
        .base_sel      (base_sel),
        .mem_la_write  (mem_la_write),
        .mem_la_addr   (mem_la_addr),
        .mem_la_wdata  (mem_la_wdata),
        .out_byte      (out_byte),
        .out_byte_en   (out_byte_en),
        .output_anodo  (output_anodo),
        .output_catodo (output_catodo)
    );

    task automatic set_row(input int i, input string n, input logic [31:0] a,
                           input logic [31:0] d, input logic b, input logic en,
                           input logic [7:0] byt);
        name_tab[i] = n;
        addr_tab[i] = a;
        data_tab[i] = d;
        base_tab[i] = b;
        en_tab[i]   = en;
        byte_tab[i] = byt;
    endtask

    task automatic fill_table;
        logic [31:0] word;
        logic [31:0] pick;
        int          i;
        set_row(0, "hex_walk", display_port_addr, 32'h1234_5678, 1'b0, 1'b1, 8'h78);
        set_row(1, "hex_letters", display_port_addr, 32'hABCD_EF09, 1'b0, 1'b1, 8'h09);
        set_row(2, "out_port_only", out_port_addr, 32'h0000_00FF, 1'b0, 1'b1, 8'h09);
        set_row(3, "other_addr", 32'h1000_0004, 32'hDEAD_BEEF, 1'b0, 1'b0, 8'h09);
        set_row(4, "dec_small", display_port_addr, 32'd12345678, 1'b1, 1'b1, 8'h4E);
        set_row(5, "dec_max8", display_port_addr, 32'd99999999, 1'b1, 1'b1, 8'hFF);
        set_row(6, "dec_capped", display_port_addr, 32'hFFFF_FFFF, 1'b1, 1'b1, 8'hFF);
        set_row(7, "dec_out_port", out_port_addr, 32'h0000_0001, 1'b1, 1'b1, 8'hFF);
        set_row(8, "low_addr", 32'h0000_0010, 32'h1111_1111, 1'b0, 1'b0, 8'hFF);
        word = 32'hFFFF_FFFF; // left by the fixed rows
        for (i = num_fixed; i < num_tests; i++) begin
            pick = $random(seed);
            if (i == num_fixed)
                pick[2:0] = 3'b100; // first random word goes out in decimal
            name_tab[i] = $sformatf("random_%0d", i - num_fixed);
            data_tab[i] = $random(seed);
            base_tab[i] = pick[2];
            case (pick[1:0])
                2'd0, 2'd1: begin
                    addr_tab[i] = display_port_addr;
                    en_tab[i]   = 1'b1;
                    word        = data_tab[i];
                end
                2'd2: begin
                    addr_tab[i] = out_port_addr;
                    en_tab[i]   = 1'b1;
                end
                default: begin
                    addr_tab[i] = {pick[31:8], 8'h08}; // hits neither port
                    en_tab[i]   = 1'b0;
                end
            endcase
            byte_tab[i] = word[7:0];
        end
    endtask

    // hex nibble or decimal place shown at position pos
    function automatic logic [3:0] expected_digit(input logic [31:0] word, input logic dec,
                                                  input int pos);
        logic [31:0] q;
        int          i;
        if (!dec)
            return 4'(word >> (4 * pos));
        q = word;
        for (i = 0; i < pos; i++)
            q = q / 32'd10;
        if (pos == num_digits - 1)
            return (q > 32'd9) ? 4'd9 : q[3:0];
        return 4'(q % 32'd10);
    endfunction

    task automatic report_mismatch(input string name, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("FAIL %s: %s expected %0h actual %0h", name, what, expected, actual);
        test_errs++;
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0)
            $display("test %s: pass", name);
        else
            $display("test %s: %0d mismatches", name, test_errs);
        errors += test_errs;
        tests_run++;
        if (test_errs != 0)
            tests_failed++;
    endtask

    task automatic check_reset;
        test_errs = 0;
        repeat (4) @(negedge clk);
        if (output_catodo !== blank_seg)
            report_mismatch("reset_state", "output_catodo", 32'(blank_seg), 32'(output_catodo));
        if (output_anodo !== 8'hFE)
            report_mismatch("reset_state", "output_anodo", 32'hFE, 32'(output_anodo));
        if (out_byte_en !== 1'b0)
            report_mismatch("reset_state", "out_byte_en", 32'h0, 32'(out_byte_en));
        if (out_byte !== 8'h00)
            report_mismatch("reset_state", "out_byte", 32'h0, 32'(out_byte));
        wait (resetn === 1'b1);
        @(negedge clk);
        if (output_anodo !== 8'hFE)
            report_mismatch("reset_state", "output_anodo after reset", 32'hFE,
                            32'(output_anodo));
        if (output_catodo !== seg_ref[0])
            report_mismatch("reset_state", "output_catodo after reset", 32'(seg_ref[0]),
                            32'(output_catodo));
        if (out_byte_en !== 1'b0 || out_byte !== 8'h00)
            report_mismatch("reset_state", "out_byte_en and out_byte after reset", 32'h0,
                            {23'h0, out_byte_en, out_byte});
        finish_test("reset_state");
    endtask

    // one full pass over all digits
    task automatic scan_check(input string name, input logic dec);
        int         c;
        int         k;
        int         zeros;
        int         pos;
        logic [7:0] seen;
        logic [7:0] exp_cat;
        seen = '0;
        for (c = 0; c < scan_cycles; c++) begin
            @(negedge clk);
            zeros = 0;
            pos   = 0;
            for (k = 0; k < num_digits; k++) begin
                if (output_anodo[k] === 1'b0) begin
                    zeros++;
                    pos = k;
                end
            end
            if (zeros != 1) begin
                $display("%s: anodes %b do not select exactly one digit", name, output_anodo);
                test_errs++;
            end else begin
                seen[pos] = 1'b1;
                exp_cat = seg_ref[expected_digit(model_word, dec, pos)];
                if (output_catodo !== exp_cat)
                    report_mismatch(name, $sformatf("cathodes at digit %0d", pos),
                                    32'(exp_cat), 32'(output_catodo));
            end
        end
        if (seen !== 8'hFF) begin
            $display("%s: scan reached only the digits %b", name, seen);
            test_errs++;
        end
    endtask

    task automatic apply_test(input int i);
        logic [7:0] prev_byte;
        test_errs = 0;
        prev_byte = (i == 0) ? 8'h00 : byte_tab[i - 1]; // mirror before this write
        @(posedge clk);
        mem_la_write <= 1'b1;
        mem_la_addr  <= addr_tab[i];
        mem_la_wdata <= data_tab[i];
        base_sel     <= base_tab[i];
        @(posedge clk); // strobe taken here
        mem_la_write <= 1'b0;
        @(negedge clk);
        if (out_byte_en !== en_tab[i])
            report_mismatch(name_tab[i], "out_byte_en", 32'(en_tab[i]), 32'(out_byte_en));
        if (out_byte !== prev_byte)
            report_mismatch(name_tab[i], "out_byte during pulse", 32'(prev_byte),
                            32'(out_byte));
        @(negedge clk);
        if (out_byte_en !== 1'b0)
            report_mismatch(name_tab[i], "out_byte_en after pulse", 32'h0, 32'(out_byte_en));
        if (out_byte !== byte_tab[i])
            report_mismatch(name_tab[i], "out_byte", 32'(byte_tab[i]), 32'(out_byte));
        if (addr_tab[i] == display_port_addr)
            model_word = data_tab[i];
        scan_check(name_tab[i], base_tab[i]);
        finish_test(name_tab[i]);
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("run stopped after %0d cycles before all tests finished", cycle_cnt);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        base_sel     = 1'b0;
        mem_la_write = 1'b0;
        mem_la_addr  = '0;
        mem_la_wdata = '0;
        seed         = 57;
        model_word   = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        fill_table();
        check_reset();
        for (int i = 0; i < num_tests; i++)
            apply_test(i);
        $display("tests run %0d, passed %0d, failed %0d, mismatches %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// ==== tb.f ====
source/bus_pkg.sv
source/display_pkg.sv
source/port_decode.sv
source/digit_scan.sv
source/segment_driver.sv
source/display_system.sv
bench/clock_gen.sv
bench/display_system_assertions.sv
bench/display_system_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the display_system testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module display_system_tb -o sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$LOG"; then
    exit 1
fi
exit 0
